// ==== hw/aesPkg.sv ====
// AES-128 shared definitions
// Block, word and byte types, round constants, controller states
// and the GF(2^8) doubling used by S-box, MixColumns and Rcon

package aesPkg;

    // Data widths
    typedef logic [7:0]   aesByteT;
    typedef logic [31:0]  aesWordT;
    typedef logic [127:0] aesBlockT;
    typedef logic [3:0]   roundCntT;

    // AES-128 round count and first round constant
    localparam roundCntT NUM_ROUNDS = 4'd10;
    localparam aesByteT  RCON_INIT  = 8'h01;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } aesStateE;

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aesByteT xtime(input aesByteT b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

// ==== hw/aesStepIf.sv ====
// AES round step interface
// Carries load/step control from the controller and the current
// round key from the key schedule to the round datapath

`timescale 1ns/1ns

interface aesStepIf
    import aesPkg::*;
    ();

    logic     load;
    logic     step;
    logic     finalRound;
    aesBlockT roundKey;

    modport ctrl     (output load, output step, output finalRound);
    modport keySched (input load, input step, output roundKey);
    modport round    (input load, input step, input finalRound, input roundKey);

endinterface

// ==== hw/aesSBox.sv ====
// AES forward S-box
// Inverse in GF(2^8) by raising to the power 254, then the affine
// transform with constant 63. Purely combinational

`timescale 1ns/1ns

module aesSBox
    import aesPkg::*;
(
    input  aesByteT inData,
    output aesByteT outData
);

    // Shift-and-add multiply in GF(2^8)
    function automatic aesByteT gfMul(input aesByteT a, input aesByteT b);
        aesByteT acc;
        aesByteT sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc ^= sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    aesByteT pow3, pow7, pow15, pow31, pow63, pow127, inv;

    // 254 = 0b11111110, square-and-multiply chain
    // zero stays zero through every step
    assign pow3   = gfMul(gfMul(inData, inData), inData);
    assign pow7   = gfMul(gfMul(pow3, pow3), inData);
    assign pow15  = gfMul(gfMul(pow7, pow7), inData);
    assign pow31  = gfMul(gfMul(pow15, pow15), inData);
    assign pow63  = gfMul(gfMul(pow31, pow31), inData);
    assign pow127 = gfMul(gfMul(pow63, pow63), inData);
    assign inv    = gfMul(pow127, pow127);

    // Affine transform as a sum of left rotations
    assign outData = inv
                   ^ {inv[6:0], inv[7]}
                   ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]}
                   ^ {inv[3:0], inv[7:4]}
                   ^ 8'h63;

endmodule

// ==== hw/aesKeyExpand.sv ====
// AES-128 key schedule
// Iterative expansion, one round key per step. The key for the
// step being taken is presented combinationally on roundKey

`timescale 1ns/1ns

module aesKeyExpand
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  aesBlockT cipherKey,
    aesStepIf.keySched stepIf
);

    aesBlockT keyReg;
    aesByteT  rcon;
    aesWordT  rotWord;
    aesWordT  subWord;
    aesWordT  temp;
    aesWordT  w0, w1, w2, w3;
    aesWordT  n0, n1, n2, n3;

    // ------------------------------------------------------------------
    // Next round key
    // ------------------------------------------------------------------
    assign {w0, w1, w2, w3} = keyReg;
    assign rotWord = {w3[23:0], w3[31:24]};

    for (genvar i = 0; i < 4; i++)
    begin : gSubWord
        aesSBox aesSBox_inst (
            .inData  (rotWord[31-8*i -: 8]),
            .outData (subWord[31-8*i -: 8])
        );
    end

    assign temp = subWord ^ {rcon, 24'h000000};

    // XOR chain across the four words
    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign stepIf.roundKey = {n0, n1, n2, n3};

    // ------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            rcon <= RCON_INIT;
        else if (stepIf.load)
            rcon <= RCON_INIT;
        else if (stepIf.step)
            rcon <= xtime(rcon);
    end

    always_ff @(posedge clk)
    begin
        if (stepIf.load)
            keyReg <= cipherKey;
        else if (stepIf.step)
            keyReg <= stepIf.roundKey;
    end

endmodule

// ==== hw/aesRound.sv ====
// AES-128 round datapath
// Holds the cipher state. One round per step: SubBytes, ShiftRows,
// MixColumns (skipped in the last round) and AddRoundKey

`timescale 1ns/1ns

module aesRound
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  aesBlockT plainText,
    input  aesBlockT cipherKey,
    aesStepIf.round  stepIf,
    output aesBlockT state
);

    aesBlockT subBlk;
    aesBlockT shiftBlk;
    aesBlockT mixBlk;
    aesBlockT nextState;

    // ------------------------------------------------------------------
    // SubBytes
    // ------------------------------------------------------------------
    // Byte n sits at [127-8n -: 8], n = 4*column + row
    for (genvar i = 0; i < 16; i++)
    begin : gSubBytes
        aesSBox aesSBox_inst (
            .inData  (state[127-8*i -: 8]),
            .outData (subBlk[127-8*i -: 8])
        );
    end

    // ------------------------------------------------------------------
    // ShiftRows
    // ------------------------------------------------------------------
    // Row r rotates left by r columns
    for (genvar i = 0; i < 16; i++)
    begin : gShiftRows
        localparam int ROW = i % 4;
        localparam int COL = i / 4;
        localparam int SRC = 4 * ((COL + ROW) % 4) + ROW;
        assign shiftBlk[127-8*i -: 8] = subBlk[127-8*SRC -: 8];
    end

    // ------------------------------------------------------------------
    // MixColumns
    // ------------------------------------------------------------------
    for (genvar c = 0; c < 4; c++)
    begin : gMixColumns
        aesByteT a0, a1, a2, a3;
        assign {a0, a1, a2, a3} = shiftBlk[127-32*c -: 32];
        assign mixBlk[127-32*c -: 32] = {
            xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
        };
    end

    // AddRoundKey
    assign nextState = (stepIf.finalRound ? shiftBlk : mixBlk) ^ stepIf.roundKey;

    // State register, initial AddRoundKey on load
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            state <= '0;
        else if (stepIf.load)
            state <= plainText ^ cipherKey;
        else if (stepIf.step)
            state <= nextState;
    end

endmodule

// ==== hw/aesCtrl.sv ====
// AES-128 controller
// Turns the four-phase req/ack handshake into one load pulse and
// ten round steps, then holds ack until req falls

`timescale 1ns/1ns

module aesCtrl
    import aesPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   req,
    output logic   ack,
    aesStepIf.ctrl stepIf
);

    aesStateE curState;
    roundCntT roundCnt;

    // ------------------------------------------------------------------
    // Step control
    // ------------------------------------------------------------------
    // Load on the edge that sees req in IDLE
    assign stepIf.load       = (curState == IDLE) && req;
    assign stepIf.step       = (curState == RUN);
    assign stepIf.finalRound = (curState == RUN) && (roundCnt == NUM_ROUNDS);

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            curState <= IDLE;
            roundCnt <= '0;
            ack      <= 1'b0;
        end
        else
        begin
            case (curState)
                IDLE:
                begin
                    if (req)
                    begin
                        curState <= RUN;
                        roundCnt <= roundCntT'(1);
                    end
                end
                RUN:
                begin
                    roundCnt <= roundCnt + roundCntT'(1);
                    // Last round written on this edge
                    if (roundCnt == NUM_ROUNDS)
                    begin
                        curState <= DONE;
                        ack      <= 1'b1;
                    end
                end
                DONE:
                begin
                    if (!req)
                    begin
                        curState <= IDLE;
                        ack      <= 1'b0;
                    end
                end
                default:
                begin
                    curState <= IDLE;
                    ack      <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== hw/aesCore.sv ====
// AES-128 encryption core
// Iterative engine, one round per clock, behind a four-phase
// req/ack handshake

`timescale 1ns/1ns

module aesCore
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     req,
    input  aesBlockT plainText,
    input  aesBlockT cipherKey,
    output logic     ack,
    output aesBlockT cipherText
);

    aesStepIf stepIf ();

    aesCtrl aesCtrl_inst (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .ack    (ack),
        .stepIf (stepIf.ctrl)
    );

    aesKeyExpand aesKeyExpand_inst (
        .clk       (clk),
        .rstN      (rstN),
        .cipherKey (cipherKey),
        .stepIf    (stepIf.keySched)
    );

    // Round state doubles as the ciphertext
    aesRound aesRound_inst (
        .clk       (clk),
        .rstN      (rstN),
        .plainText (plainText),
        .cipherKey (cipherKey),
        .stepIf    (stepIf.round),
        .state     (cipherText)
    );

endmodule

// ==== tests/aesCore_sva.sv ====
// AES-128 core handshake assertions
// Bound to aesCore, checks the four-phase req/ack protocol

`timescale 1ns/1ns

module aesCore_sva
    import aesPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     req,
    input logic     ack,
    input aesBlockT cipherText
);

    // ack only rises for a request that is pending
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req high");

    // ack only falls once req has been seen low
    ackFallAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ack) |-> $past(!req))
        else $error("ack fell while req was still high");

    // Result held while ack is high
    textStable: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> (!ack || $stable(cipherText)))
        else $error("cipherText changed while ack was high");

endmodule

bind aesCore aesCore_sva aesCore_sva_inst (
    .clk        (clk),
    .rstN       (rstN),
    .req        (req),
    .ack        (ack),
    .cipherText (cipherText)
);

// ==== tests/aesCoreTb.sv ====
// AES-128 core testbench
// FIPS-197 vectors, random blocks against a reference model,
// handshake timing, reset values and back-pressure

`timescale 1ns/1ns

module aesCoreTb
    import aesPkg::*;
();

    // About 30 requests of 15 cycles plus reset and a 50-cycle stall
    localparam int MAX_CYCLES = 2000;

    logic     clk;
    logic     rstN;
    logic     req;
    aesBlockT plainText;
    aesBlockT cipherKey;
    logic     ack;
    aesBlockT cipherText;

    integer     seed;
    int         errCnt;
    int         cycleCnt;
    logic       ackPrev;
    aesBlockT   heldText;
    aesBlockT   expQ [$];
    logic [7:0] sboxTab [256];

    aesCore aesCore_inst (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .plainText  (plainText),
        .cipherKey  (cipherKey),
        .ack        (ack),
        .cipherText (cipherText)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [7:0] mulGf(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p ^= x;
            x = (x << 1) ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Inverse by exhaustive search and the FIPS-197 affine equation
    function automatic logic [7:0] sboxEntry(input int x);
        logic [7:0] inv;
        logic [7:0] r;
        inv = 8'h00;
        for (int y = 1; y < 256; y++)
            if (mulGf(8'(x), 8'(y)) == 8'h01)
                inv = 8'(y);
        for (int i = 0; i < 8; i++)
            r[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
        return r ^ 8'h63;
    endfunction

    function automatic aesBlockT aesRef(input aesBlockT pt, input aesBlockT key);
        logic [7:0] s [16];
        logic [7:0] t [16];
        logic [7:0] k [16];
        logic [7:0] rc;
        aesBlockT   res;
        for (int i = 0; i < 16; i++)
        begin
            k[i] = key[127-8*i -: 8];
            s[i] = pt[127-8*i -: 8] ^ k[i];
        end
        rc = 8'h01;
        for (int r = 1; r <= 10; r++)
        begin
            // Key schedule on RotWord of the last column
            k[0] = k[0] ^ sboxTab[k[13]] ^ rc;
            k[1] = k[1] ^ sboxTab[k[14]];
            k[2] = k[2] ^ sboxTab[k[15]];
            k[3] = k[3] ^ sboxTab[k[12]];
            for (int i = 4; i < 16; i++)
                k[i] = k[i] ^ k[i-4];
            rc = mulGf(rc, 8'h02);
            // SubBytes with ShiftRows folded into the source index
            for (int c = 0; c < 4; c++)
                for (int w = 0; w < 4; w++)
                    t[4*c+w] = sboxTab[s[4*((c+w)%4)+w]];
            for (int c = 0; c < 4; c++)
                for (int w = 0; w < 4; w++)
                    if (r == 10)
                        s[4*c+w] = t[4*c+w] ^ k[4*c+w];
                    else
                        s[4*c+w] = mulGf(t[4*c+w], 8'h02) ^ mulGf(t[4*c+(w+1)%4], 8'h03)
                                 ^ t[4*c+(w+2)%4] ^ t[4*c+(w+3)%4] ^ k[4*c+w];
        end
        for (int i = 0; i < 16; i++)
            res[127-8*i -: 8] = s[i];
        return res;
    endfunction

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic checkValue(input string name, input aesBlockT expVal, input aesBlockT actVal);
        if (actVal !== expVal)
        begin
            errCnt++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
        end
    endtask

    // First ack cycle pops the next expected result
    always @(negedge clk)
    begin
        if (rstN && ack && !ackPrev)
        begin
            if (expQ.size() == 0)
            begin
                errCnt++;
                $display("Handshake failure at %0t: ack rose with no request pending", $time);
                heldText = cipherText;
            end
            else
            begin
                heldText = expQ.pop_front();
                checkValue("cipherText", heldText, cipherText);
            end
        end
        else if (rstN && ack)
            checkValue("cipherText held", heldText, cipherText);
        ackPrev = ack;
    end

    always @(posedge clk)
    begin
        cycleCnt++;
        if (cycleCnt >= MAX_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles with %0d errors", cycleCnt, errCnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    function automatic aesBlockT randBlock();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic runRequest(input aesBlockT pt, input aesBlockT key,
                              input aesBlockT expCt, input int holdCycles);
        int edges;
        expQ.push_back(expCt);
        @(posedge clk);
        plainText <= pt;
        cipherKey <= key;
        req       <= 1'b1;
        edges = 0;
        // Count from the first edge that samples req high
        do
        begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        while (!ack && edges < 20);
        checkValue("ackLatency", 11, edges);
        // Back-pressure keeps ack high
        repeat (holdCycles)
        begin
            @(posedge clk);
            @(negedge clk);
            checkValue("ack", 1, ack);
        end
        @(posedge clk);
        req <= 1'b0;
        // This edge still sampled req high
        @(negedge clk);
        checkValue("ack", 1, ack);
        @(posedge clk);
        @(negedge clk);
        if (ack)
        begin
            errCnt++;
            $display("Handshake failure at %0t: ack still high after req was sampled low", $time);
        end
    endtask

    initial
    begin
        aesBlockT pt;
        aesBlockT key;
        clk       = 1'b0;
        rstN      = 1'b0;
        req       = 1'b0;
        plainText = '0;
        cipherKey = '0;
        seed      = 32'he880_ecbd;
        errCnt    = 0;
        cycleCnt  = 0;
        ackPrev   = 1'b0;
        for (int i = 0; i < 256; i++)
            sboxTab[i] = sboxEntry(i);

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        // Idle after reset
        repeat (4)
        begin
            @(negedge clk);
            checkValue("ack", 0, ack);
            checkValue("cipherText", 0, cipherText);
        end

        // FIPS-197 Appendix B and C.1
        pt  = 128'h3243f6a8885a308d313198a2e0370734;
        key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        checkValue("refModel", 128'h3925841d02dc09fbdc118597196a0b32, aesRef(pt, key));
        runRequest(pt, key, 128'h3925841d02dc09fbdc118597196a0b32, 0);
        pt  = 128'h00112233445566778899aabbccddeeff;
        key = 128'h000102030405060708090a0b0c0d0e0f;
        checkValue("refModel", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, aesRef(pt, key));
        runRequest(pt, key, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 0);

        for (int n = 0; n < 20; n++)
        begin
            pt  = randBlock();
            key = randBlock();
            runRequest(pt, key, aesRef(pt, key), 0);
        end

        // Stall in DONE and then requests back to back
        pt  = randBlock();
        key = randBlock();
        runRequest(pt, key, aesRef(pt, key), 50);
        for (int n = 0; n < 5; n++)
        begin
            pt  = randBlock();
            key = randBlock();
            runRequest(pt, key, aesRef(pt, key), 0);
        end

        checkValue("pendingResults", 0, expQ.size());
        $display("Errors: %0d", errCnt);
        if (errCnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== aesCore.f ====
hw/aesPkg.sv
hw/aesStepIf.sv
hw/aesSBox.sv
hw/aesKeyExpand.sv
hw/aesRound.sv
hw/aesCtrl.sv
hw/aesCore.sv
tests/aesCore_sva.sv
tests/aesCoreTb.sv
